/* hw/lcd_pkg.sv */
`default_nettype none

package lcd_pkg;

    // ========================================
    // Writer word and panel geometry
    // ========================================

    localparam int word_w = 9;              // Bit 8 is the dc flag

    localparam int panel_width  = 240;
    localparam int panel_height = 320;

    // ========================================
    // ST7789V opcodes and parameter bytes
    // ========================================

    typedef enum logic [7:0] {
        SLPOUT = 8'h11,                     // Sleep out
        NORON  = 8'h13,                     // Normal display mode
        INVON  = 8'h21,                     // Inversion on
        DISPON = 8'h29,                     // Display on
        CASET  = 8'h2A,                     // Column window
        RASET  = 8'h2B,                     // Row window
        RAMWR  = 8'h2C,                     // Start of pixel stream
        MADCTL = 8'h36,                     // Scan direction
        COLMOD = 8'h3A                      // Pixel format
    } lcd_cmd_e;

    localparam logic [7:0] colmod_rgb565 = 8'h55;
    localparam logic [7:0] madctl_normal = 8'h00;

    // ========================================
    // FSM states
    // ========================================

    typedef enum logic [2:0] {
        HOLD_RESET,
        WAKE_WAIT,
        SEND_INIT,
        SETTLE_WAIT,
        SEND_WINDOW,
        INIT_DONE
    } init_state_e;

    typedef enum logic [1:0] {
        ARB_INIT,
        ARB_FILL,
        ARB_DONE
    } arb_state_e;

endpackage

`default_nettype wire

/* hw/lcd_init_seq.sv */
`timescale 1ns/1ns
`default_nettype none

module lcd_init_seq #(
    parameter int reset_cycles  = 327680,
    parameter int wake_cycles   = 1048576,
    parameter int settle_cycles = 2097152
) (
    input  wire logic                         clk_50mhz,
    input  wire logic                         rst_n,
    output logic                              lcd_rst,
    output logic [lcd_pkg::word_w-1:0]        init_word,
    output logic                              init_en,
    input  wire logic                         init_done_pulse,
    output logic                              init_complete
);

    localparam int max_delay = (reset_cycles > wake_cycles) ?
        ((reset_cycles > settle_cycles) ? reset_cycles : settle_cycles) :
        ((wake_cycles > settle_cycles) ? wake_cycles : settle_cycles);
    localparam int cnt_w = $clog2(max_delay + 2);

    localparam logic [15:0] col_end = 16'(lcd_pkg::panel_width - 1);
    localparam logic [15:0] row_end = 16'(lcd_pkg::panel_height - 1);

    localparam logic [3:0] init_len   = 4'd8;
    localparam logic [3:0] window_len = 4'd11;

    lcd_pkg::init_state_e state;
    logic [cnt_w-1:0]     cnt;
    logic [3:0]           step;

    // ========================================
    // Word tables
    // ========================================

    function automatic logic [lcd_pkg::word_w-1:0] init_entry(input logic [3:0] idx);
        case (idx)
            4'd0:    return {1'b0, lcd_pkg::SLPOUT};
            4'd1:    return {1'b0, lcd_pkg::COLMOD};
            4'd2:    return {1'b1, lcd_pkg::colmod_rgb565};
            4'd3:    return {1'b0, lcd_pkg::MADCTL};
            4'd4:    return {1'b1, lcd_pkg::madctl_normal};
            4'd5:    return {1'b0, lcd_pkg::INVON};
            4'd6:    return {1'b0, lcd_pkg::NORON};
            default: return {1'b0, lcd_pkg::DISPON};
        endcase
    endfunction

    // Start at 0,0 and end at the far corner
    function automatic logic [lcd_pkg::word_w-1:0] window_entry(input logic [3:0] idx);
        case (idx)
            4'd0:    return {1'b0, lcd_pkg::CASET};
            4'd1:    return 9'h100;
            4'd2:    return 9'h100;
            4'd3:    return {1'b1, col_end[15:8]};
            4'd4:    return {1'b1, col_end[7:0]};
            4'd5:    return {1'b0, lcd_pkg::RASET};
            4'd6:    return 9'h100;
            4'd7:    return 9'h100;
            4'd8:    return {1'b1, row_end[15:8]};
            4'd9:    return {1'b1, row_end[7:0]};
            default: return {1'b0, lcd_pkg::RAMWR};
        endcase
    endfunction

    // ========================================
    // Sequencer
    // ========================================

    always_ff @(posedge clk_50mhz or negedge rst_n) begin
        if (!rst_n) begin
            state     <= lcd_pkg::HOLD_RESET;
            cnt       <= '0;
            step      <= '0;
            lcd_rst   <= 1'b0;
            init_word <= '0;
            init_en   <= 1'b0;
        end else begin
            case (state)
                lcd_pkg::HOLD_RESET: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == cnt_w'(reset_cycles)) begin
                        cnt     <= '0;
                        lcd_rst <= 1'b1;            // Release panel
                        state   <= lcd_pkg::WAKE_WAIT;
                    end
                end
                lcd_pkg::WAKE_WAIT: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == cnt_w'(wake_cycles)) begin
                        cnt   <= '0;
                        step  <= '0;
                        state <= lcd_pkg::SEND_INIT;
                    end
                end
                lcd_pkg::SEND_INIT: begin
                    if (!init_en) begin
                        init_word <= init_entry(step);
                        init_en   <= 1'b1;
                        step      <= step + 1'b1;
                    end else if (init_done_pulse) begin
                        init_en <= 1'b0;
                        if (step == init_len) begin
                            state <= lcd_pkg::SETTLE_WAIT;   // DISPON accepted
                        end
                    end
                end
                lcd_pkg::SETTLE_WAIT: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == cnt_w'(settle_cycles)) begin
                        cnt   <= '0;
                        step  <= '0;
                        state <= lcd_pkg::SEND_WINDOW;
                    end
                end
                lcd_pkg::SEND_WINDOW: begin
                    if (!init_en) begin
                        init_word <= window_entry(step);
                        init_en   <= 1'b1;
                        step      <= step + 1'b1;
                    end else if (init_done_pulse) begin
                        init_en <= 1'b0;
                        if (step == window_len) begin
                            state <= lcd_pkg::INIT_DONE;     // RAMWR accepted
                        end
                    end
                end
                lcd_pkg::INIT_DONE: begin
                    init_en <= 1'b0;
                end
                default: state <= lcd_pkg::HOLD_RESET;
            endcase
        end
    end

    assign init_complete = (state == lcd_pkg::INIT_DONE);

endmodule

`default_nettype wire

/* hw/lcd_pixel_fill.sv */
`timescale 1ns/1ns
`default_nettype none

module lcd_pixel_fill #(
    parameter int          pixel_count = 76800,
    parameter logic [15:0] fill_color  = 16'hFFFF
) (
    input  wire logic                         clk_50mhz,
    input  wire logic                         rst_n,
    input  wire logic                         fill_go,
    output logic [lcd_pkg::word_w-1:0]        fill_word,
    output logic                              fill_en,
    input  wire logic                         fill_done_pulse,
    output logic                              fill_last
);

    localparam int pix_w = $clog2(pixel_count + 1);

    logic [pix_w-1:0] pix_cnt;                      // Pixels fully sent
    logic             lo_byte;                      // Low byte is next
    logic             all_sent;

    assign all_sent = (pix_cnt == pix_w'(pixel_count));

    always_ff @(posedge clk_50mhz or negedge rst_n) begin
        if (!rst_n) begin
            pix_cnt <= '0;
            lo_byte <= 1'b0;
            fill_en <= 1'b0;
        end else if (!fill_en) begin
            if (fill_go && !all_sent) begin
                fill_en <= 1'b1;
            end
        end else if (fill_done_pulse) begin
            fill_en <= 1'b0;
            lo_byte <= ~lo_byte;
            if (lo_byte) begin
                pix_cnt <= pix_cnt + 1'b1;
            end
        end
    end

    // Byte select only moves on done, so the word is stable under en
    assign fill_word = lo_byte ? {1'b1, fill_color[7:0]} : {1'b1, fill_color[15:8]};

    assign fill_last = fill_en && lo_byte && (pix_cnt == pix_w'(pixel_count - 1));

endmodule

`default_nettype wire

/* hw/lcd_write_arbiter.sv */
`timescale 1ns/1ns
`default_nettype none

module lcd_write_arbiter (
    input  wire logic                         clk_50mhz,
    input  wire logic                         rst_n,
    input  wire logic [lcd_pkg::word_w-1:0]   init_word,
    input  wire logic                         init_en,
    input  wire logic                         init_complete,
    output logic                              init_done_pulse,
    input  wire logic [lcd_pkg::word_w-1:0]   fill_word,
    input  wire logic                         fill_en,
    input  wire logic                         fill_last,
    output logic                              fill_done_pulse,
    output logic                              fill_go,
    output logic [lcd_pkg::word_w-1:0]        wr_word,
    output logic                              wr_en,
    input  wire logic                         wr_done,
    output logic                              frame_done
);

    lcd_pkg::arb_state_e state;

    always_ff @(posedge clk_50mhz or negedge rst_n) begin
        if (!rst_n) begin
            state <= lcd_pkg::ARB_INIT;
        end else begin
            case (state)
                lcd_pkg::ARB_INIT: begin
                    if (init_complete) begin
                        state <= lcd_pkg::ARB_FILL;
                    end
                end
                lcd_pkg::ARB_FILL: begin
                    if (fill_last && wr_done) begin
                        state <= lcd_pkg::ARB_DONE;  // Last low byte out
                    end
                end
                lcd_pkg::ARB_DONE: state <= lcd_pkg::ARB_DONE;
                default:           state <= lcd_pkg::ARB_INIT;
            endcase
        end
    end

    // ========================================
    // Source steering
    // ========================================

    assign fill_go    = (state == lcd_pkg::ARB_FILL);
    assign frame_done = (state == lcd_pkg::ARB_DONE);

    assign wr_word = fill_go ? fill_word : init_word;
    assign wr_en   = (state == lcd_pkg::ARB_INIT) ? init_en :
                     fill_go                      ? fill_en : 1'b0;   // Idle once done

    assign init_done_pulse = (state == lcd_pkg::ARB_INIT) && wr_done;
    assign fill_done_pulse = fill_go && wr_done;

endmodule

`default_nettype wire

/* hw/lcd_spi_write.sv */
`timescale 1ns/1ns
`default_nettype none

module lcd_spi_write #(
    parameter int sclk_half = 2
) (
    input  wire logic                         clk_50mhz,
    input  wire logic                         rst_n,
    input  wire logic [lcd_pkg::word_w-1:0]   wr_word,
    input  wire logic                         wr_en,
    output logic                              wr_done,
    output logic                              cs,
    output logic                              sclk,
    output logic                              dc,
    output logic                              mosi
);

    localparam int div_w = (sclk_half > 1) ? $clog2(sclk_half) : 1;

    localparam logic [div_w-1:0] div_last  = div_w'(sclk_half - 1);
    localparam logic [4:0]       half_last = 5'd15;     // Eighth high phase
    localparam logic [4:0]       half_end  = 5'd16;

    logic             busy;
    logic [div_w-1:0] div;                              // Clocks within a half period
    logic [4:0]       half;                             // Half periods elapsed
    logic [6:0]       shift;                            // Bits after the MSB

    // ========================================
    // Serialiser
    // ========================================

    always_ff @(posedge clk_50mhz or negedge rst_n) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            div     <= '0;
            half    <= '0;
            shift   <= '0;
            cs      <= 1'b1;
            sclk    <= 1'b1;
            dc      <= 1'b0;
            mosi    <= 1'b0;
            wr_done <= 1'b0;
        end else begin
            wr_done <= 1'b0;
            if (!busy) begin
                // En is still high in the done cycle
                if (wr_en && !wr_done) begin
                    busy  <= 1'b1;
                    cs    <= 1'b0;
                    sclk  <= 1'b0;                      // First falling edge
                    dc    <= wr_word[8];
                    mosi  <= wr_word[7];
                    shift <= wr_word[6:0];
                    div   <= '0;
                    half  <= '0;
                end
            end else if (half == half_end) begin
                busy    <= 1'b0;
                cs      <= 1'b1;
                wr_done <= 1'b1;
            end else if (div == div_last) begin
                div  <= '0;
                half <= half + 1'b1;
                if (half != half_last) begin
                    sclk <= ~sclk;
                    if (sclk) begin
                        mosi  <= shift[6];              // Next bit on falling edge
                        shift <= {shift[5:0], 1'b0};
                    end
                end
            end else begin
                div <= div + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/lcd_display_top.sv */
`timescale 1ns/1ns
`default_nettype none

module lcd_display_top #(
    parameter int          reset_cycles  = 327680,
    parameter int          wake_cycles   = 1048576,
    parameter int          settle_cycles = 2097152,
    parameter int          pixel_count   = 76800,
    parameter logic [15:0] fill_color    = 16'hFFFF,
    parameter int          sclk_half     = 2
) (
    input  wire logic clk_50mhz,
    input  wire logic rst_n,
    output logic      lcd_rst,
    output logic      lcd_blk,
    output logic      lcd_dc,
    output logic      lcd_sclk,
    output logic      lcd_mosi,
    output logic      lcd_cs,
    output logic      led1,
    output logic      led2
);

    logic [lcd_pkg::word_w-1:0] init_word;
    logic                       init_en;
    logic                       init_done_pulse;
    logic                       init_complete;

    logic [lcd_pkg::word_w-1:0] fill_word;
    logic                       fill_en;
    logic                       fill_done_pulse;
    logic                       fill_last;
    logic                       fill_go;

    logic [lcd_pkg::word_w-1:0] wr_word;
    logic                       wr_en;
    logic                       wr_done;
    logic                       frame_done;

    // ========================================
    // Command and pixel sources
    // ========================================

    lcd_init_seq #(
        .reset_cycles  (reset_cycles),
        .wake_cycles   (wake_cycles),
        .settle_cycles (settle_cycles)
    ) u_init_seq (
        .clk_50mhz       (clk_50mhz),
        .rst_n           (rst_n),
        .lcd_rst         (lcd_rst),
        .init_word       (init_word),
        .init_en         (init_en),
        .init_done_pulse (init_done_pulse),
        .init_complete   (init_complete)
    );

    lcd_pixel_fill #(
        .pixel_count (pixel_count),
        .fill_color  (fill_color)
    ) u_pixel_fill (
        .clk_50mhz       (clk_50mhz),
        .rst_n           (rst_n),
        .fill_go         (fill_go),
        .fill_word       (fill_word),
        .fill_en         (fill_en),
        .fill_done_pulse (fill_done_pulse),
        .fill_last       (fill_last)
    );

    // ========================================
    // Shared SPI link
    // ========================================

    lcd_write_arbiter u_arbiter (
        .clk_50mhz       (clk_50mhz),
        .rst_n           (rst_n),
        .init_word       (init_word),
        .init_en         (init_en),
        .init_complete   (init_complete),
        .init_done_pulse (init_done_pulse),
        .fill_word       (fill_word),
        .fill_en         (fill_en),
        .fill_last       (fill_last),
        .fill_done_pulse (fill_done_pulse),
        .fill_go         (fill_go),
        .wr_word         (wr_word),
        .wr_en           (wr_en),
        .wr_done         (wr_done),
        .frame_done      (frame_done)
    );

    lcd_spi_write #(
        .sclk_half (sclk_half)
    ) u_spi_write (
        .clk_50mhz (clk_50mhz),
        .rst_n     (rst_n),
        .wr_word   (wr_word),
        .wr_en     (wr_en),
        .wr_done   (wr_done),
        .cs        (lcd_cs),
        .sclk      (lcd_sclk),
        .dc        (lcd_dc),
        .mosi      (lcd_mosi)
    );

    assign lcd_blk = 1'b1;                      // Backlight always on
    assign led1    = lcd_rst;                   // Panel out of reset
    assign led2    = frame_done;

endmodule

`default_nettype wire

/* tb/lcd_display_chk.sv */
`timescale 1ns/1ns
`default_nettype none

module lcd_display_chk #(
    parameter int sclk_half = 2
) (
    input  wire logic                         clk_50mhz,
    input  wire logic                         rst_n,
    input  wire logic [lcd_pkg::word_w-1:0]   wr_word,
    input  wire logic                         wr_en,
    input  wire logic                         wr_done,
    input  wire logic                         cs,
    input  wire logic                         sclk,
    input  wire logic                         dc,
    input  wire logic                         mosi
);

    localparam int cs_low_cycles = 16 * sclk_half + 1;

    int          fail_count = 0;                   // Failed assertions so far
    logic [15:0] low_len;                          // Cycles cs has been low

    always_ff @(posedge clk_50mhz or negedge rst_n) begin
        if (!rst_n) begin
            low_len <= '0;
        end else if (!cs) begin
            low_len <= low_len + 16'd1;
        end else begin
            low_len <= '0;
        end
    end

    // ========================================
    // SPI framing
    // ========================================

    cs_frame_len: assert property (@(posedge clk_50mhz) disable iff (!rst_n)
        $rose(cs) |-> (low_len == 16'(cs_low_cycles)))
        else begin
            fail_count++;
            $error("cs low phase is not %0d cycles long", cs_low_cycles);
        end

    data_setup: assert property (@(posedge clk_50mhz) disable iff (!rst_n)
        $rose(sclk) |-> ($stable(dc) && $stable(mosi)))
        else begin
            fail_count++;
            $error("dc or mosi changed together with an sclk rise");
        end

    data_hold: assert property (@(posedge clk_50mhz) disable iff (!rst_n)
        $rose(sclk) |=> ($stable(dc) && $stable(mosi)))
        else begin
            fail_count++;
            $error("dc or mosi changed right after an sclk rise");
        end

    // ========================================
    // Request and done rules
    // ========================================

    done_at_cs_rise: assert property (@(posedge clk_50mhz) disable iff (!rst_n)
        wr_done == $rose(cs))
        else begin
            fail_count++;
            $error("wr_done and the cs rise are not in the same cycle");
        end

    done_one_cycle: assert property (@(posedge clk_50mhz) disable iff (!rst_n)
        wr_done |-> (wr_en ##1 !wr_done))
        else begin
            fail_count++;
            $error("wr_done without a request or longer than one cycle");
        end

    request_held: assert property (@(posedge clk_50mhz) disable iff (!rst_n)
        (wr_en && !wr_done) |=> (wr_en && $stable(wr_word)))
        else begin
            fail_count++;
            $error("Request dropped or word changed before done");
        end

    request_dropped: assert property (@(posedge clk_50mhz) disable iff (!rst_n)
        wr_done |=> !wr_en)
        else begin
            fail_count++;
            $error("Request still high in the cycle after done");
        end

endmodule

bind lcd_spi_write lcd_display_chk #(
    .sclk_half (sclk_half)
) u_chk (
    .clk_50mhz (clk_50mhz),
    .rst_n     (rst_n),
    .wr_word   (wr_word),
    .wr_en     (wr_en),
    .wr_done   (wr_done),
    .cs        (cs),
    .sclk      (sclk),
    .dc        (dc),
    .mosi      (mosi)
);

`default_nettype wire

/* tb/lcd_display_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module lcd_display_tb;

    localparam int          reset_cycles  = 8;
    localparam int          wake_cycles   = 12;
    localparam int          settle_cycles = 16;
    localparam int          pixel_count   = 20;
    localparam logic [15:0] fill_color    = 16'hA5C3;
    localparam int          sclk_half     = 2;

    localparam int word_cycles     = 16 * sclk_half + 4;   // cs low plus handshake gap
    localparam int total_words     = 19 + 2 * pixel_count;
    localparam int watchdog_cycles =
        2 * (reset_cycles + wake_cycles + settle_cycles + total_words * word_cycles);

    logic      clk_50mhz;
    logic      rst_n;
    wire logic lcd_rst;
    wire logic lcd_blk;
    wire logic lcd_dc;
    wire logic lcd_sclk;
    wire logic lcd_mosi;
    wire logic lcd_cs;
    wire logic led1;
    wire logic led2;

    logic [lcd_pkg::word_w-1:0] exp_q[$];
    logic [7:0]                 shift_in;
    logic                       word_dc;
    logic                       prev_sclk;
    logic                       prev_cs;
    int                         word_count;
    int                         rst_low_cnt;
    int                         rst_high_cnt;
    int                         errors;
    int                         chk_fails;

    lcd_display_top #(
        .reset_cycles  (reset_cycles),
        .wake_cycles   (wake_cycles),
        .settle_cycles (settle_cycles),
        .pixel_count   (pixel_count),
        .fill_color    (fill_color),
        .sclk_half     (sclk_half)
    ) dut (
        .clk_50mhz (clk_50mhz),
        .rst_n     (rst_n),
        .lcd_rst   (lcd_rst),
        .lcd_blk   (lcd_blk),
        .lcd_dc    (lcd_dc),
        .lcd_sclk  (lcd_sclk),
        .lcd_mosi  (lcd_mosi),
        .lcd_cs    (lcd_cs),
        .led1      (led1),
        .led2      (led2)
    );

    always #10 clk_50mhz = ~clk_50mhz;

    task automatic note_mismatch(input string name, input int exp_v, input int got_v);
        errors++;
        $display("error: t=%0t %s expected 'h%0h got 'h%0h", $time, name, exp_v, got_v);
    endtask

    task automatic note_failure(input string what);
        errors++;
        $display("%s (at %0t ns)", what, $time);
    endtask

    task automatic push_word(input logic is_data, input logic [7:0] value);
        exp_q.push_back({is_data, value});
    endtask

    // ========================================
    // Expected word list
    // ========================================

    task automatic build_expected();
        logic [15:0] col_last;
        logic [15:0] row_last;
        col_last = 16'(lcd_pkg::panel_width - 1);
        row_last = 16'(lcd_pkg::panel_height - 1);
        push_word(1'b0, lcd_pkg::SLPOUT);
        push_word(1'b0, lcd_pkg::COLMOD);
        push_word(1'b1, lcd_pkg::colmod_rgb565);
        push_word(1'b0, lcd_pkg::MADCTL);
        push_word(1'b1, lcd_pkg::madctl_normal);
        push_word(1'b0, lcd_pkg::INVON);
        push_word(1'b0, lcd_pkg::NORON);
        push_word(1'b0, lcd_pkg::DISPON);
        push_word(1'b0, lcd_pkg::CASET);
        push_word(1'b1, 8'h00);
        push_word(1'b1, 8'h00);
        push_word(1'b1, col_last[15:8]);
        push_word(1'b1, col_last[7:0]);
        push_word(1'b0, lcd_pkg::RASET);
        push_word(1'b1, 8'h00);
        push_word(1'b1, 8'h00);
        push_word(1'b1, row_last[15:8]);
        push_word(1'b1, row_last[7:0]);
        push_word(1'b0, lcd_pkg::RAMWR);
        for (int i = 0; i < pixel_count; i++) begin
            push_word(1'b1, fill_color[15:8]);       // High byte first
            push_word(1'b1, fill_color[7:0]);
        end
    endtask

    task automatic check_word(input logic [lcd_pkg::word_w-1:0] got);
        if (word_count < exp_q.size()) begin
            assert (got == exp_q[word_count]) else
                note_mismatch($sformatf("spi word %0d {dc,data}", word_count),
                              exp_q[word_count], got);
        end else begin
            note_failure("Extra SPI word decoded after the end of the frame");
        end
        word_count++;
    endtask

    // ========================================
    // Pin monitor, sampled on the falling clock edge
    // ========================================

    always @(negedge clk_50mhz) begin
        if (rst_n) begin
            if (!lcd_cs && lcd_sclk && !prev_sclk) begin
                shift_in = {shift_in[6:0], lcd_mosi};   // MSB arrives first
                word_dc  = lcd_dc;
            end
            if (lcd_cs && !prev_cs) begin
                check_word({word_dc, shift_in});
            end
            if (!lcd_rst) begin
                rst_low_cnt++;
            end else begin
                if (rst_high_cnt == 0) begin
                    assert (rst_low_cnt == reset_cycles + 1) else
                        note_mismatch("lcd_rst low cycles", reset_cycles + 1, rst_low_cnt);
                end
                rst_high_cnt++;
            end
            if (!lcd_cs && prev_cs) begin
                assert (rst_high_cnt > wake_cycles + 1) else
                    note_failure("cs went low before the panel wake time had passed");
            end
            assert (led1 == lcd_rst) else
                note_mismatch("led1", lcd_rst, led1);
            assert (lcd_blk === 1'b1) else
                note_mismatch("lcd_blk", 1, lcd_blk);
            if (led2) begin
                assert (word_count == exp_q.size()) else
                    note_mismatch("words decoded at led2", exp_q.size(), word_count);
                assert (lcd_cs) else
                    note_failure("cs active after the frame was reported done");
            end
            prev_sclk = lcd_sclk;
            prev_cs   = lcd_cs;
        end
    end

    initial begin
        clk_50mhz    = 1'b0;
        rst_n        = 1'b0;
        shift_in     = '0;
        word_dc      = 1'b0;
        prev_sclk    = 1'b1;
        prev_cs      = 1'b1;
        word_count   = 0;
        rst_low_cnt  = 0;
        rst_high_cnt = 0;
        errors       = 0;
        build_expected();
        repeat (4) @(posedge clk_50mhz);
        #2 rst_n = 1'b1;
        wait (led2 === 1'b1);
        repeat (4 * word_cycles) @(posedge clk_50mhz);   // Link must stay idle
        if (word_count != exp_q.size()) begin
            note_failure("Frame ended with the wrong number of SPI words");
        end
        chk_fails = dut.u_spi_write.u_chk.fail_count;
        $display("Result: %0d of %0d words, %0d monitor errors, %0d assertion failures",
                 word_count, exp_q.size(), errors, chk_fails);
        if (errors == 0 && chk_fails == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk_50mhz);
        $display("Watchdog expired: led2 did not rise within %0d clock cycles",
                 watchdog_cycles);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* lcd_display.f */
hw/lcd_pkg.sv
hw/lcd_init_seq.sv
hw/lcd_pixel_fill.sv
hw/lcd_write_arbiter.sv
hw/lcd_spi_write.sv
hw/lcd_display_top.sv
tb/lcd_display_chk.sv
tb/lcd_display_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build with Verilator, run, and pass only if the pass line is printed
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ns \
    --top-module lcd_display_tb -f lcd_display.f -o lcd_sim \
    || { echo "Verilator build failed"; exit 1; }

sim_out=$(./obj_dir/lcd_sim +verilator+error+limit+1000)
echo "$sim_out"

echo "$sim_out" | grep -qxF "Simulation finished: PASS" && exit 0 || exit 1
